// ==== lms_fe_pkg.sv ====
// LMS6002D front end shared widths and SPI device map
`default_nettype none

package lms_fe_pkg;

   // Sample widths
   localparam int LMS_SAMPLE_W  = 12;   // LMS ADC/DAC word
   localparam int CORE_SAMPLE_W = 14;   // Core side sample
   localparam int PAD_W         = 2;    // Zero bits below a received word

   // Shared SPI bus
   localparam int SPI_DEV_N = 3;

   // Slave positions within select and per-device vectors
   localparam int SPI_DEV_DAC  = 0;
   localparam int SPI_DEV_LMS1 = 1;
   localparam int SPI_DEV_LMS2 = 2;

endpackage

`default_nettype wire

// ==== lms_rx_deinterleave.sv ====
// LMS receive deinterleaver, rebuilds I/Q pairs from the IQ-select tagged ADC words
`timescale 1ns/1ps
`default_nettype none

module lms_rx_deinterleave
   import lms_fe_pkg::*;
(
   input  logic                     lms_clk,
   input  logic                     rst_n_i,
   input  logic                     rx_iqsel_i,   // High marks an I word
   input  logic [LMS_SAMPLE_W-1:0]  rx_d_i,
   output logic [CORE_SAMPLE_W-1:0] rx_i_o,
   output logic [CORE_SAMPLE_W-1:0] rx_q_o,
   output logic                     rx_valid_o
);

   logic [LMS_SAMPLE_W-1:0] i_hold;   // Most recent I word
   logic                    i_pend;
   logic                    pair_done;

   // A Q word closes a pair only once an I word has been seen
   assign pair_done = !rx_iqsel_i && i_pend;

   always_ff @(posedge lms_clk)
   begin
      if (!rst_n_i)
      begin
         i_pend     <= 1'b0;
         rx_valid_o <= 1'b0;
      end
      else
      begin
         rx_valid_o <= pair_done;
         if (rx_iqsel_i)
            i_pend <= 1'b1;
         else if (pair_done)
            i_pend <= 1'b0;
      end
   end

   // Sample payload
   always_ff @(posedge lms_clk)
   begin
      if (rx_iqsel_i)
         i_hold <= rx_d_i;   // Repeated I words overwrite
      if (pair_done)
      begin
         rx_i_o <= {i_hold, {PAD_W{1'b0}}};   // Left justified
         rx_q_o <= {rx_d_i, {PAD_W{1'b0}}};
      end
   end

   // Each pair needs at least one I word and one Q word, so no back to back strobes
   assert property (@(posedge lms_clk) disable iff (!rst_n_i)
                    rx_valid_o |=> !rx_valid_o)
      else $error("rx_valid_o high in two consecutive cycles");

endmodule

`default_nettype wire

// ==== lms_tx_interleave.sv ====
// LMS transmit interleaver, buffers I/Q pairs under credit control and slots them onto the DAC bus
`timescale 1ns/1ps
`default_nettype none

module lms_tx_interleave
   import lms_fe_pkg::*;
#(
   parameter int TX_DEPTH = 4
)
(
   input  logic                    lms_clk,
   input  logic                    rst_n_i,
   input  logic                    tx_push_i,
   input  logic [LMS_SAMPLE_W-1:0] tx_i_i,
   input  logic [LMS_SAMPLE_W-1:0] tx_q_i,
   output logic                    tx_credit_o,   // One credit back per pop
   output logic                    tx_iqsel_o,    // Low on I slot, high on Q slot
   output logic [LMS_SAMPLE_W-1:0] tx_d_o,
   output logic                    tx_underrun_o
);

   localparam int PTR_W = $clog2(TX_DEPTH);
   localparam int CNT_W = $clog2(TX_DEPTH + 1);

   logic [LMS_SAMPLE_W-1:0] buf_i [TX_DEPTH];
   logic [LMS_SAMPLE_W-1:0] buf_q [TX_DEPTH];
   logic [PTR_W-1:0]        wr_ptr;
   logic [PTR_W-1:0]        rd_ptr;
   logic [CNT_W-1:0]        fill;
   logic                    slot_q;   // Next slot is the Q slot
   logic [LMS_SAMPLE_W-1:0] q_hold;
   logic                    armed;    // Set once any pair went in
   logic                    buf_full;
   logic                    buf_empty;
   logic                    wr_en;
   logic                    rd_en;

   function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
      return (ptr == PTR_W'(TX_DEPTH - 1)) ? '0 : ptr + 1'b1;
   endfunction

   assign buf_full  = (fill == CNT_W'(TX_DEPTH));
   assign buf_empty = (fill == '0);
   assign wr_en     = tx_push_i && !buf_full;
   assign rd_en     = !slot_q && !buf_empty;   // Pop only at an I slot

   // Pair storage
   always_ff @(posedge lms_clk)
   begin
      if (wr_en)
      begin
         buf_i[wr_ptr] <= tx_i_i;
         buf_q[wr_ptr] <= tx_q_i;
      end
   end

   // Q word waits one slot behind its I word, zero on an empty I slot
   always_ff @(posedge lms_clk)
   begin
      if (!slot_q)
         q_hold <= rd_en ? buf_q[rd_ptr] : '0;
   end

   always_ff @(posedge lms_clk)
   begin
      if (!rst_n_i)
      begin
         wr_ptr        <= '0;
         rd_ptr        <= '0;
         fill          <= '0;
         slot_q        <= 1'b0;   // First slot after reset is I
         armed         <= 1'b0;
         tx_credit_o   <= 1'b0;
         tx_iqsel_o    <= 1'b0;
         tx_d_o        <= '0;
         tx_underrun_o <= 1'b0;
      end
      else
      begin
         if (wr_en)
            wr_ptr <= ptr_next(wr_ptr);
         if (rd_en)
            rd_ptr <= ptr_next(rd_ptr);
         fill        <= fill + CNT_W'(wr_en) - CNT_W'(rd_en);
         slot_q      <= !slot_q;
         tx_iqsel_o  <= slot_q;
         tx_credit_o <= rd_en;    // Same cycle as the I word it frees
         armed       <= armed | wr_en;
         if (!slot_q)
         begin
            tx_d_o <= rd_en ? buf_i[rd_ptr] : '0;
            if (buf_empty && armed)
               tx_underrun_o <= 1'b1;   // Sticky until reset
         end
         else
            tx_d_o <= q_hold;
      end
   end

   // Core must honour its credits, so a full buffer never sees a push
   assert property (@(posedge lms_clk) disable iff (!rst_n_i)
                    tx_push_i |-> !buf_full)
      else $error("push into full TX buffer, credit protocol broken");

   // Slots alternate I, Q, I, Q from the first slot after reset
   assert property (@(posedge lms_clk) disable iff (!rst_n_i)
                    $past(rst_n_i) |=> tx_iqsel_o != $past(tx_iqsel_o))
      else $error("tx_iqsel_o did not alternate");

endmodule

`default_nettype wire

// ==== lms_spi_fanout.sv ====
// SPI select fan-out, gates the shared master onto the DAC and both LMS chips
`timescale 1ns/1ps
`default_nettype none

module lms_spi_fanout
   import lms_fe_pkg::*;
(
   input  logic                 lms_clk,       // Assertion sampling only
   input  logic                 spi_sclk_i,
   input  logic                 spi_mosi_i,
   input  logic [SPI_DEV_N-1:0] spi_sen_n_i,   // Active low selects
   output logic                 spi_miso_o,
   output logic [SPI_DEV_N-1:0] dev_sclk_o,
   output logic [SPI_DEV_N-1:0] dev_mosi_o,
   input  logic [1:0]           lms_miso_i     // [0] LMS1, [1] LMS2
);

   logic [SPI_DEV_N-1:0] dev_miso;

   // Idle devices see both lines held low
   always_comb
   begin
      for (int d = 0; d < SPI_DEV_N; d++)
      begin
         dev_sclk_o[d] = !spi_sen_n_i[d] && spi_sclk_i;
         dev_mosi_o[d] = !spi_sen_n_i[d] && spi_mosi_i;
      end
   end

   // Per-device readback, DAC is write only
   always_comb
   begin
      dev_miso               = '0;
      dev_miso[SPI_DEV_DAC]  = 1'b0;
      dev_miso[SPI_DEV_LMS1] = lms_miso_i[0];
      dev_miso[SPI_DEV_LMS2] = lms_miso_i[1];
   end

   assign spi_miso_o = |(dev_miso & ~spi_sen_n_i);

   // Master addresses one slave at a time
   assert property (@(posedge lms_clk) $onehot0(~spi_sen_n_i))
      else $error("more than one SPI select low");

endmodule

`default_nettype wire

// ==== lms_frontend_top.sv ====
// LMS6002D front end top, two receive and two transmit channels plus SPI select fan-out
`timescale 1ns/1ps
`default_nettype none

module lms_frontend_top
   import lms_fe_pkg::*;
#(
   parameter int TX_DEPTH = 4
)
(
   input  logic                     lms_clk,
   input  logic                     rst_n_i,
   // LMS1 and LMS2 ADC side
   input  logic                     rx1_iqsel_i,
   input  logic [LMS_SAMPLE_W-1:0]  rx1_d_i,
   input  logic                     rx2_iqsel_i,
   input  logic [LMS_SAMPLE_W-1:0]  rx2_d_i,
   output logic [CORE_SAMPLE_W-1:0] rx1_i_o,
   output logic [CORE_SAMPLE_W-1:0] rx1_q_o,
   output logic                     rx1_valid_o,
   output logic [CORE_SAMPLE_W-1:0] rx2_i_o,
   output logic [CORE_SAMPLE_W-1:0] rx2_q_o,
   output logic                     rx2_valid_o,
   // Core transmit side, credit based
   input  logic                     tx1_push_i,
   input  logic [LMS_SAMPLE_W-1:0]  tx1_i_i,
   input  logic [LMS_SAMPLE_W-1:0]  tx1_q_i,
   output logic                     tx1_credit_o,
   input  logic                     tx2_push_i,
   input  logic [LMS_SAMPLE_W-1:0]  tx2_i_i,
   input  logic [LMS_SAMPLE_W-1:0]  tx2_q_i,
   output logic                     tx2_credit_o,
   // LMS1 and LMS2 DAC side
   output logic                     tx1_iqsel_o,
   output logic [LMS_SAMPLE_W-1:0]  tx1_d_o,
   output logic                     tx1_underrun_o,
   output logic                     tx2_iqsel_o,
   output logic [LMS_SAMPLE_W-1:0]  tx2_d_o,
   output logic                     tx2_underrun_o,
   // SPI
   input  logic                     spi_sclk_i,
   input  logic                     spi_mosi_i,
   input  logic [SPI_DEV_N-1:0]     spi_sen_n_i,
   output logic                     spi_miso_o,
   output logic [SPI_DEV_N-1:0]     dev_sclk_o,
   output logic [SPI_DEV_N-1:0]     dev_mosi_o,
   input  logic [1:0]               lms_miso_i
);

   lms_rx_deinterleave rx1_deint_i (
      .lms_clk    (lms_clk),
      .rst_n_i    (rst_n_i),
      .rx_iqsel_i (rx1_iqsel_i),
      .rx_d_i     (rx1_d_i),
      .rx_i_o     (rx1_i_o),
      .rx_q_o     (rx1_q_o),
      .rx_valid_o (rx1_valid_o)
   );

   lms_rx_deinterleave rx2_deint_i (
      .lms_clk    (lms_clk),
      .rst_n_i    (rst_n_i),
      .rx_iqsel_i (rx2_iqsel_i),
      .rx_d_i     (rx2_d_i),
      .rx_i_o     (rx2_i_o),
      .rx_q_o     (rx2_q_o),
      .rx_valid_o (rx2_valid_o)
   );

   lms_tx_interleave #(.TX_DEPTH(TX_DEPTH)) tx1_intl_i (
      .lms_clk       (lms_clk),
      .rst_n_i       (rst_n_i),
      .tx_push_i     (tx1_push_i),
      .tx_i_i        (tx1_i_i),
      .tx_q_i        (tx1_q_i),
      .tx_credit_o   (tx1_credit_o),
      .tx_iqsel_o    (tx1_iqsel_o),
      .tx_d_o        (tx1_d_o),
      .tx_underrun_o (tx1_underrun_o)
   );

   lms_tx_interleave #(.TX_DEPTH(TX_DEPTH)) tx2_intl_i (
      .lms_clk       (lms_clk),
      .rst_n_i       (rst_n_i),
      .tx_push_i     (tx2_push_i),
      .tx_i_i        (tx2_i_i),
      .tx_q_i        (tx2_q_i),
      .tx_credit_o   (tx2_credit_o),
      .tx_iqsel_o    (tx2_iqsel_o),
      .tx_d_o        (tx2_d_o),
      .tx_underrun_o (tx2_underrun_o)
   );

   lms_spi_fanout spi_fanout_i (
      .lms_clk     (lms_clk),
      .spi_sclk_i  (spi_sclk_i),
      .spi_mosi_i  (spi_mosi_i),
      .spi_sen_n_i (spi_sen_n_i),
      .spi_miso_o  (spi_miso_o),
      .dev_sclk_o  (dev_sclk_o),
      .dev_mosi_o  (dev_mosi_o),
      .lms_miso_i  (lms_miso_i)
   );

endmodule

`default_nettype wire

// ==== tb_lms_frontend.sv ====
// LMS front end testbench driving the receive, transmit and SPI paths against assertion checks
`timescale 1ns/1ps
`default_nettype none

module tb_lms_frontend;

   localparam int DEPTH = 4;
   localparam int TMO   = 200;   // Cycles allowed per wait loop

   logic        lms_clk = 1'b0;
   logic        rst_n_i;
   logic [1:0]  rx_iqsel;
   logic [11:0] rx_d [2];
   logic [13:0] rx_i [2];
   logic [13:0] rx_q [2];
   logic [1:0]  rx_valid;
   logic [1:0]  tx_push;
   logic [11:0] tx_i [2];
   logic [11:0] tx_q [2];
   logic [1:0]  tx_credit;
   logic [1:0]  tx_iqsel;
   logic [1:0]  tx_underrun;
   logic [11:0] tx_d [2];
   logic        spi_sclk;
   logic        spi_mosi;
   logic        spi_miso;
   logic [2:0]  spi_sen_n;
   logic [2:0]  dev_sclk;
   logic [2:0]  dev_mosi;
   logic [1:0]  lms_miso;

   integer seed = 32'hcba29d91;
   int     errors = 0;
   int     credits [2];
   int     push_cnt [2];
   int     credit_cnt [2];
   int     sb_size [2];
   int     n;
   bit     timed_out = 0;
   bit     rst_chk = 0;
   bit     spi_chk = 0;
   bit     idle_chk = 0;

   always #5 lms_clk = !lms_clk;

   lms_frontend_top #(.TX_DEPTH(DEPTH)) dut_i (
      .lms_clk(lms_clk), .rst_n_i(rst_n_i),
      .rx1_iqsel_i(rx_iqsel[0]), .rx1_d_i(rx_d[0]), .rx2_iqsel_i(rx_iqsel[1]), .rx2_d_i(rx_d[1]),
      .rx1_i_o(rx_i[0]), .rx1_q_o(rx_q[0]), .rx1_valid_o(rx_valid[0]),
      .rx2_i_o(rx_i[1]), .rx2_q_o(rx_q[1]), .rx2_valid_o(rx_valid[1]),
      .tx1_push_i(tx_push[0]), .tx1_i_i(tx_i[0]), .tx1_q_i(tx_q[0]), .tx1_credit_o(tx_credit[0]),
      .tx2_push_i(tx_push[1]), .tx2_i_i(tx_i[1]), .tx2_q_i(tx_q[1]), .tx2_credit_o(tx_credit[1]),
      .tx1_iqsel_o(tx_iqsel[0]), .tx1_d_o(tx_d[0]), .tx1_underrun_o(tx_underrun[0]),
      .tx2_iqsel_o(tx_iqsel[1]), .tx2_d_o(tx_d[1]), .tx2_underrun_o(tx_underrun[1]),
      .spi_sclk_i(spi_sclk), .spi_mosi_i(spi_mosi), .spi_sen_n_i(spi_sen_n),
      .spi_miso_o(spi_miso), .dev_sclk_o(dev_sclk), .dev_mosi_o(dev_mosi), .lms_miso_i(lms_miso)
   );

   function automatic logic [11:0] rand_nonzero();
      logic [11:0] v;
      v = 12'($random(seed));
      return (v == '0) ? 12'h001 : v;   // Zero is reserved for underrun slots
   endfunction

   // MISO of the selected LMS chip or zero for the DAC and no select
   function automatic logic selected_miso(input logic [2:0] sen_n, input logic [1:0] miso);
      if (!sen_n[1])
         return miso[0];
      else if (!sen_n[2])
         return miso[1];
      else
         return 1'b0;
   endfunction

   // Reset values of the control outputs
   assert property (@(posedge lms_clk) rst_chk |-> rx_valid == 0 && tx_credit == 0
                    && tx_underrun == 0)
      else begin
         errors++;
         $display("[ERROR] %0t rx_valid_o/tx_credit_o/tx_underrun_o expected 0 got %b/%b/%b",
                  $time, $sampled(rx_valid), $sampled(tx_credit), $sampled(tx_underrun));
      end

   assert property (@(posedge lms_clk) rst_chk |-> tx_iqsel == 0 && tx_d[0] == 0
                    && tx_d[1] == 0)
      else begin
         errors++;
         $display("[ERROR] %0t tx_iqsel_o/tx_d_o expected 0/0 got %b/%h %h", $time,
                  $sampled(tx_iqsel), $sampled(tx_d[0]), $sampled(tx_d[1]));
      end

   // SPI gating and MISO selection from the select rules
   assert property (@(posedge lms_clk) spi_chk |-> dev_sclk == ({3{spi_sclk}} & ~spi_sen_n)
                    && dev_mosi == ({3{spi_mosi}} & ~spi_sen_n))
      else begin
         errors++;
         $display("[ERROR] %0t dev_sclk_o/dev_mosi_o expected %b/%b got %b/%b", $time,
                  $sampled({3{spi_sclk}} & ~spi_sen_n), $sampled({3{spi_mosi}} & ~spi_sen_n),
                  $sampled(dev_sclk), $sampled(dev_mosi));
      end

   assert property (@(posedge lms_clk)
                    spi_chk |-> spi_miso == selected_miso(spi_sen_n, lms_miso))
      else begin
         errors++;
         $display("[ERROR] %0t spi_miso_o expected %b got %b with selects %b", $time,
                  selected_miso($sampled(spi_sen_n), $sampled(lms_miso)), $sampled(spi_miso),
                  $sampled(spi_sen_n));
      end

   for (genvar c = 0; c < 2; c++)
   begin : chan
      logic [11:0] i_last;
      logic        i_seen;
      logic        exp_valid;
      logic [13:0] exp_i;
      logic [13:0] exp_q;
      logic [23:0] sb [$];
      logic [23:0] head;
      logic [11:0] exp_qword;

      // Receive reference where a Q word closes a pair once an I word was seen
      always @(posedge lms_clk)
      begin
         if (!rst_n_i)
         begin
            i_seen    <= 1'b0;
            exp_valid <= 1'b0;
         end
         else
         begin
            exp_valid <= !rx_iqsel[c] && i_seen;
            if (!rx_iqsel[c] && i_seen)
            begin
               exp_i  <= {i_last, 2'b00};
               exp_q  <= {rx_d[c], 2'b00};
               i_seen <= 1'b0;
            end
            if (rx_iqsel[c])
            begin
               i_last <= rx_d[c];
               i_seen <= 1'b1;
            end
         end
      end

      assert property (@(posedge lms_clk) disable iff (!rst_n_i) rx_valid[c] == exp_valid)
         else begin
            errors++;
            $display("[ERROR] %0t rx%0d_valid_o expected %b got %b", $time, c + 1,
                     $sampled(exp_valid), $sampled(rx_valid[c]));
         end

      assert property (@(posedge lms_clk) disable iff (!rst_n_i)
                       exp_valid |-> rx_i[c] == exp_i && rx_q[c] == exp_q)
         else begin
            errors++;
            $display("[ERROR] %0t rx%0d_i_o/rx%0d_q_o expected %h/%h got %h/%h", $time, c + 1,
                     c + 1, $sampled(exp_i), $sampled(exp_q), $sampled(rx_i[c]),
                     $sampled(rx_q[c]));
         end

      // Transmit scoreboard popped by each nonzero I slot
      always @(posedge lms_clk)
      begin
         if (rst_n_i)
         begin
            if (tx_push[c])
               sb.push_back({tx_i[c], tx_q[c]});
            if (tx_credit[c])
            begin
               credits[c]++;
               credit_cnt[c]++;
            end
            if (!tx_iqsel[c] && tx_d[c] != 0)
            begin
               if (sb.size() == 0)
               begin
                  errors++;
                  $display("Channel %0d sent a word at %0t with nothing pushed", c + 1, $time);
               end
               else
               begin
                  head = sb.pop_front();
                  exp_qword <= head[11:0];
                  assert (tx_d[c] == head[23:12])
                     else begin
                        errors++;
                        $display("[ERROR] %0t tx%0d_d_o expected %h got %h", $time, c + 1,
                                 head[23:12], tx_d[c]);
                     end
               end
            end
            sb_size[c] = sb.size();
         end
      end

      assert property (@(posedge lms_clk) disable iff (!rst_n_i)
                       (!tx_iqsel[c] && tx_d[c] != 0) |=> tx_iqsel[c] && tx_d[c] == exp_qword)
         else begin
            errors++;
            $display("[ERROR] %0t tx%0d_d_o Q slot expected %h got %h (iqsel %b)", $time, c + 1,
                     $sampled(exp_qword), $sampled(tx_d[c]), $sampled(tx_iqsel[c]));
         end

      assert property (@(posedge lms_clk) disable iff (!rst_n_i)
                       (!tx_iqsel[c] && tx_d[c] != 0) |-> tx_credit[c])
         else begin
            errors++;
            $display("[ERROR] %0t tx%0d_credit_o expected 1 got 0", $time, c + 1);
         end

      assert property (@(posedge lms_clk) disable iff (!rst_n_i) tx_underrun[c] |=> tx_underrun[c])
         else begin
            errors++;
            $display("[ERROR] %0t tx%0d_underrun_o expected 1 got 0", $time, c + 1);
         end

      assert property (@(posedge lms_clk) idle_chk |-> tx_d[c] == 0 && tx_underrun[c])
         else begin
            errors++;
            $display("[ERROR] %0t tx%0d_d_o idle expected 0 got %h, underrun %b", $time, c + 1,
                     $sampled(tx_d[c]), $sampled(tx_underrun[c]));
         end
   end

   initial
   begin
      rst_n_i   = 1'b0;
      rx_iqsel  = '0;
      rx_d[0]   = '0;
      rx_d[1]   = '0;
      tx_push   = '0;
      tx_i[0]   = '0;
      tx_i[1]   = '0;
      tx_q[0]   = '0;
      tx_q[1]   = '0;
      spi_sclk  = 1'b0;
      spi_mosi  = 1'b0;
      spi_sen_n = 3'b111;
      lms_miso  = '0;
      for (int c = 0; c < 2; c++)
      begin
         credits[c]    = DEPTH;
         push_cnt[c]   = 0;
         credit_cnt[c] = 0;
         sb_size[c]    = 0;
      end

      // Test 1 checks the reset state and the first slot after it
      repeat (2) @(posedge lms_clk);
      #1 rst_chk = 1'b1;
      repeat (8) @(posedge lms_clk);
      #1 rst_n_i = 1'b1;
      repeat (2) @(posedge lms_clk);
      #1 rst_chk = 1'b0;
      $display("Test 1 reset state done, errors %0d", errors);

      // Test 2 sends stray Q words first and then random tagged words
      for (int k = 0; k < 203; k++)
      begin
         for (int c = 0; c < 2; c++)
         begin
            rx_iqsel[c] = (k < 3) ? 1'b0 : 1'($random(seed));
            rx_d[c]     = 12'($random(seed));
         end
         @(posedge lms_clk);
         #1;
      end
      rx_iqsel = '0;
      $display("Test 2 receive reconstruction done, errors %0d", errors);

      // Test 3 pushes random pairs under credit control
      for (int k = 0; k < 300; k++)
      begin
         for (int c = 0; c < 2; c++)
         begin
            tx_push[c] = 1'b0;
            if (credits[c] > 0 && ($random(seed) & 1))
            begin
               tx_push[c] = 1'b1;
               tx_i[c]    = rand_nonzero();
               tx_q[c]    = rand_nonzero();
               credits[c]--;
               push_cnt[c]++;
            end
         end
         @(posedge lms_clk);
         #1;
      end
      tx_push = '0;
      $display("Test 3 transmit order done, errors %0d", errors);

      // Test 4 drains the buffers and counts the returned credits
      n = 0;
      while (!(sb_size[0] == 0 && sb_size[1] == 0 && credits[0] == DEPTH && credits[1] == DEPTH)
             && n < TMO)
      begin
         @(posedge lms_clk);
         #1 n++;
      end
      if (n >= TMO)
      begin
         timed_out = 1'b1;
         $display("Timed out waiting for the transmit buffers to drain");
      end
      for (int c = 0; c < 2; c++)
         if (push_cnt[c] != credit_cnt[c] || credits[c] != DEPTH)
         begin
            errors++;
            $display("[ERROR] %0t tx%0d_credit_o pulses expected %0d got %0d, credits %0d",
                     $time, c + 1, push_cnt[c], credit_cnt[c], credits[c]);
         end
      $display("Test 4 credit accounting done, errors %0d", errors);

      // Test 5 waits for underrun after the last pair left
      n = 0;
      while (tx_underrun != 2'b11 && n < TMO)
      begin
         @(posedge lms_clk);
         #1 n++;
      end
      if (n >= TMO)
      begin
         timed_out = 1'b1;
         $display("Timed out waiting for tx_underrun_o on both channels");
      end
      repeat (2) @(posedge lms_clk);
      #1 idle_chk = 1'b1;
      repeat (20) @(posedge lms_clk);
      #1 idle_chk = 1'b0;
      $display("Test 5 underrun done, errors %0d", errors);

      // Test 6 drives one select at a time and then none
      spi_chk = 1'b1;
      for (int s = 0; s < 4; s++)
      begin
         spi_sen_n = (s < 3) ? ~(3'b001 << s) : 3'b111;
         for (int k = 0; k < 8; k++)
         begin
            spi_sclk = 1'($random(seed));
            spi_mosi = 1'($random(seed));
            lms_miso = 2'($random(seed));
            @(posedge lms_clk);
            #1;
         end
      end
      spi_chk   = 1'b0;
      spi_sen_n = 3'b111;
      $display("Test 6 SPI fan-out done, errors %0d", errors);

      $display("Tests run 6, errors %0d, timeouts %0d", errors, timed_out);
      if (errors == 0 && !timed_out)
         $display("Simulation passed");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== project.f ====
lms_fe_pkg.sv
lms_rx_deinterleave.sv
lms_tx_interleave.sv
lms_spi_fanout.sv
lms_frontend_top.sv
tb_lms_frontend.sv

// ==== Bender.yml ====
package:
  name: lms_frontend

sources:
  - lms_fe_pkg.sv
  - lms_rx_deinterleave.sv
  - lms_tx_interleave.sv
  - lms_spi_fanout.sv
  - lms_frontend_top.sv
  - target: simulation
    files:
      - tb_lms_frontend.sv
